// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// register and immediate width
`define CPU_DATA_W 32

// program memory address width
`define CPU_PROG_AW 16

// lowest byte address of the register bank
`define CPU_REG_BASE 8'he0

`endif

// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // decode phases of the control sequencer
    typedef enum logic [4:0] {
        FETCH    = 5'd0,
        EXEC     = 5'd1,
        FILL_IMM = 5'd2
    } phase_t;

    // operations understood by the ALU
    typedef enum logic [5:0] {
        ALU_NOP  = 6'd0,
        ALU_MOVE = 6'd1
    } alu_op_t;

    // register byte address, E0h to FFh in use
    typedef logic [7:0] reg_addr_t;

    // one-hot write width: 001 byte, 010 word, 100 long
    typedef logic [2:0] width_t;

    // opcode bytes consumed in one step
    typedef logic [1:0] fetch_cnt_t;

endpackage

// File: hdl/op_fetch.sv
`timescale 1ns/10ps

`include "cpu_config.svh"

module op_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  cpu_pkg::fetch_cnt_t     fetched,
    output logic [`CPU_PROG_AW-1:0] prog_addr,
    input  logic [`CPU_DATA_W-1:0]  prog_data,
    input  logic                    prog_ok,
    output logic [`CPU_DATA_W-1:0]  op,
    output logic                    op_ok
);

    logic [`CPU_PROG_AW-1:0] pc;
    logic                    addr_seen; // memory has seen pc for a full cycle
    logic                    take;

    assign prog_addr = pc;

    // window is only accepted once the memory answered for the current pc
    assign take = addr_seen && prog_ok && !op_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= '0;
            addr_seen <= 1'b0;
            op_ok     <= 1'b0;
        end else if (cen) begin
            if (fetched != 2'd0) begin
                pc        <= pc + `CPU_PROG_AW'(fetched);
                addr_seen <= 1'b0; // old answer is stale now
                op_ok     <= 1'b0;
            end else begin
                addr_seen <= 1'b1;
                if (take) begin
                    op_ok <= 1'b1;
                end
            end
        end
    end

    // opcode window itself
    always_ff @(posedge clk) begin
        if (cen && fetched == 2'd0 && take) begin
            op <= prog_data;
        end
    end

endmodule

// File: hdl/cpu_ctrl.sv
`timescale 1ns/10ps

`include "cpu_config.svh"

module cpu_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic [`CPU_DATA_W-1:0] op,
    input  logic                   op_ok,
    output cpu_pkg::fetch_cnt_t    fetched,
    output logic [`CPU_DATA_W-1:0] alu_imm,
    output cpu_pkg::alu_op_t       alu_op,
    output logic                   alu_smux,
    output logic                   alu_wait,
    output cpu_pkg::width_t        regs_we,
    output cpu_pkg::reg_addr_t     regs_dst,
    output cpu_pkg::reg_addr_t     regs_src
);

    cpu_pkg::phase_t       op_phase, nx_phase;
    cpu_pkg::alu_op_t      nx_alu_op;
    cpu_pkg::width_t       nx_regs_we;
    cpu_pkg::reg_addr_t    nx_dst, nx_src;
    logic [`CPU_DATA_W-1:0] nx_alu_imm;
    logic                  nx_alu_smux, nx_alu_wait;
    logic [1:0]            op_zz, nx_op_zz; // operand size, 0 byte 1 word 2 long
    logic                  ram_wait;        // window is stale right after a fetch

    function automatic cpu_pkg::width_t expand_zz(input logic [1:0] zz);
        if (zz == 2'd0)
            return 3'b001;
        else if (zz == 2'd1)
            return 3'b010;
        else
            return 3'b100;
    endfunction

    // 3-bit register code to byte address
    function automatic cpu_pkg::reg_addr_t expand_reg(input logic [2:0] code,
                                                      input logic [1:0] zz);
        logic [7:0] ofs;
        if (zz == 2'd0)
            ofs = {4'd0, code[2:1], 1'b0, ~code[0]}; // byte regs sit low in each long
        else
            ofs = {3'd0, code, 2'd0};
        return `CPU_REG_BASE + ofs;
    endfunction

    always_comb begin
        fetched     = 2'd0;
        nx_phase    = op_phase;
        nx_src      = regs_src;
        nx_dst      = regs_dst;
        nx_alu_op   = alu_op;
        nx_alu_imm  = alu_imm;
        nx_alu_smux = alu_smux;
        nx_alu_wait = alu_wait;
        nx_regs_we  = regs_we;
        nx_op_zz    = op_zz;
        // the write is done once the sequencer is back in FETCH
        if (op_phase == cpu_pkg::FETCH) begin
            nx_alu_op   = cpu_pkg::ALU_NOP;
            nx_alu_smux = 1'b0;
            nx_alu_wait = 1'b0;
            nx_regs_we  = '0;
        end
        if (op_ok && !ram_wait) begin
            case (op_phase)
                cpu_pkg::FETCH: begin
                    casez (op[7:0])
                        8'h00: fetched = 2'd1; // NOP
                        8'b11??_1???: begin // short r prefix
                            nx_op_zz = op[5:4];
                            nx_dst   = expand_reg(op[2:0], op[5:4]);
                            nx_phase = cpu_pkg::EXEC;
                            fetched  = 2'd1;
                        end
                        8'b11??_0111: begin // prefix with full register address
                            nx_op_zz = op[5:4];
                            nx_dst   = op[15:8];
                            nx_phase = cpu_pkg::EXEC;
                            fetched  = 2'd2;
                        end
                        8'b0010_0???,
                        8'b0011_0???,
                        8'b0100_0???: begin // LD R,#
                            nx_op_zz    = op[6:4] == 3'd2 ? 2'd0 :
                                          op[6:4] == 3'd3 ? 2'd1 : 2'd2;
                            nx_dst      = expand_reg(op[2:0], nx_op_zz);
                            nx_alu_imm  = {24'd0, op[15:8]};
                            nx_alu_op   = cpu_pkg::ALU_MOVE;
                            nx_alu_smux = 1'b1;
                            nx_regs_we  = expand_zz(nx_op_zz);
                            fetched     = 2'd2;
                            if (nx_op_zz != 2'd0) begin
                                nx_alu_wait = 1'b1; // upper bytes still missing
                                nx_phase    = cpu_pkg::FILL_IMM;
                            end
                        end
                        default: ; // undecoded, stall
                    endcase
                end
                cpu_pkg::EXEC: begin
                    casez (op[7:0])
                        8'b1000_1???: begin // LD R,r
                            nx_src     = regs_dst;
                            nx_dst     = expand_reg(op[2:0], op_zz);
                            nx_alu_op  = cpu_pkg::ALU_MOVE;
                            nx_regs_we = expand_zz(op_zz);
                            nx_phase   = cpu_pkg::FETCH;
                            fetched    = 2'd1;
                        end
                        8'b1001_1???: begin // LD r,R
                            nx_src     = expand_reg(op[2:0], op_zz);
                            nx_alu_op  = cpu_pkg::ALU_MOVE;
                            nx_regs_we = expand_zz(op_zz);
                            nx_phase   = cpu_pkg::FETCH;
                            fetched    = 2'd1;
                        end
                        8'b1010_1???: begin // LD r,#3
                            nx_alu_imm  = {29'd0, op[2:0]};
                            nx_alu_op   = cpu_pkg::ALU_MOVE;
                            nx_alu_smux = 1'b1;
                            nx_regs_we  = expand_zz(op_zz);
                            nx_phase    = cpu_pkg::FETCH;
                            fetched     = 2'd1;
                        end
                        8'b0000_0011: begin // LD r,#
                            nx_alu_imm  = {24'd0, op[15:8]};
                            nx_alu_op   = cpu_pkg::ALU_MOVE;
                            nx_alu_smux = 1'b1;
                            nx_regs_we  = expand_zz(op_zz);
                            fetched     = 2'd2;
                            if (op_zz != 2'd0) begin
                                nx_alu_wait = 1'b1;
                                nx_phase    = cpu_pkg::FILL_IMM;
                            end else begin
                                nx_phase    = cpu_pkg::FETCH;
                            end
                        end
                        default: ;
                    endcase
                end
                cpu_pkg::FILL_IMM: begin
                    nx_alu_wait = 1'b0;
                    nx_phase    = cpu_pkg::FETCH;
                    if (op_zz == 2'd1) begin
                        nx_alu_imm[31:8] = {16'd0, op[7:0]};
                        fetched          = 2'd1;
                    end else begin
                        nx_alu_imm[31:8] = op[23:0];
                        fetched          = 2'd3;
                    end
                end
                default: nx_phase = cpu_pkg::FETCH;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_phase <= cpu_pkg::FETCH;
            regs_src <= '0;
            regs_dst <= '0;
            alu_op   <= cpu_pkg::ALU_NOP;
            alu_imm  <= '0;
            alu_smux <= 1'b0;
            alu_wait <= 1'b0;
            regs_we  <= '0;
            op_zz    <= 2'd0;
            ram_wait <= 1'b0;
        end else if (cen) begin
            op_phase <= nx_phase;
            regs_src <= nx_src;
            regs_dst <= nx_dst;
            alu_op   <= nx_alu_op;
            alu_imm  <= nx_alu_imm;
            alu_smux <= nx_alu_smux;
            alu_wait <= nx_alu_wait;
            regs_we  <= nx_regs_we;
            op_zz    <= nx_op_zz;
            ram_wait <= fetched != 2'd0;
        end
    end

endmodule

// File: hdl/move_alu.sv
`timescale 1ns/10ps

`include "cpu_config.svh"

module move_alu (
    input  cpu_pkg::alu_op_t       alu_op,
    input  logic [`CPU_DATA_W-1:0] alu_imm,
    input  logic                   alu_smux,
    input  logic                   alu_wait,
    input  cpu_pkg::width_t        regs_we,
    input  logic [`CPU_DATA_W-1:0] src_data,
    output logic [`CPU_DATA_W-1:0] wr_data,
    output logic                   wr_en
);

    logic is_move;
    logic any_width;

    assign is_move   = alu_op == cpu_pkg::ALU_MOVE;
    assign any_width = |regs_we;

    // immediate or register operand
    always_comb begin
        if (alu_smux)
            wr_data = alu_imm;
        else
            wr_data = src_data;
    end

    // held off while the immediate is still being filled
    assign wr_en = is_move && !alu_wait && any_width;

endmodule

// File: hdl/reg_bank.sv
`timescale 1ns/10ps

`include "cpu_config.svh"

module reg_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   wr_en,
    input  cpu_pkg::width_t        regs_we,
    input  cpu_pkg::reg_addr_t     regs_dst,
    input  logic [`CPU_DATA_W-1:0] wr_data,
    input  cpu_pkg::reg_addr_t     regs_src,
    output logic [`CPU_DATA_W-1:0] src_data,
    input  cpu_pkg::reg_addr_t     dbg_addr,
    output logic [`CPU_DATA_W-1:0] dbg_data
);

    logic [7:0] mem [32];
    logic [4:0] wr_base, src_base, dbg_base;
    logic [3:0] byte_en;

    // byte offsets inside the bank
    assign wr_base  = 5'(regs_dst - `CPU_REG_BASE);
    assign src_base = 5'(regs_src - `CPU_REG_BASE);
    assign dbg_base = 5'(dbg_addr - `CPU_REG_BASE);

    assign byte_en = {regs_we[2], regs_we[2], regs_we[2] | regs_we[1], |regs_we};

    // four bytes little-endian that wrap at the top of the bank
    function automatic logic [`CPU_DATA_W-1:0] read_long(input logic [4:0] base);
        logic [`CPU_DATA_W-1:0] val;
        for (int i = 0; i < 4; i++) begin
            val[8*i +: 8] = mem[base + 5'(i)];
        end
        return val;
    endfunction

    always_comb begin
        src_data = read_long(src_base);
    end

    always_comb begin
        dbg_data = read_long(dbg_base);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '{default: '0};
        end else if (cen && wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[wr_base + 5'(i)] <= wr_data[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/10ps

`include "cpu_config.svh"

module cpu_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    output logic [`CPU_PROG_AW-1:0] prog_addr,
    input  logic [`CPU_DATA_W-1:0]  prog_data,
    input  logic                    prog_ok,
    input  cpu_pkg::reg_addr_t      dbg_addr,
    output logic [`CPU_DATA_W-1:0]  dbg_data
);

    logic [`CPU_DATA_W-1:0] op;
    logic                   op_ok;
    cpu_pkg::fetch_cnt_t    fetched;
    logic [`CPU_DATA_W-1:0] alu_imm;
    cpu_pkg::alu_op_t       alu_op;
    logic                   alu_smux;
    logic                   alu_wait;
    cpu_pkg::width_t        regs_we;
    cpu_pkg::reg_addr_t     regs_dst;
    cpu_pkg::reg_addr_t     regs_src;
    logic [`CPU_DATA_W-1:0] src_data;
    logic [`CPU_DATA_W-1:0] wr_data;
    logic                   wr_en;

    op_fetch u_fetch (
        .clk(clk), .rst(rst), .cen(cen), .fetched(fetched),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_ok(prog_ok),
        .op(op), .op_ok(op_ok)
    );

    cpu_ctrl u_ctrl (
        .clk(clk), .rst(rst), .cen(cen), .op(op), .op_ok(op_ok),
        .fetched(fetched), .alu_imm(alu_imm), .alu_op(alu_op),
        .alu_smux(alu_smux), .alu_wait(alu_wait), .regs_we(regs_we),
        .regs_dst(regs_dst), .regs_src(regs_src)
    );

    move_alu u_alu (
        .alu_op(alu_op), .alu_imm(alu_imm), .alu_smux(alu_smux),
        .alu_wait(alu_wait), .regs_we(regs_we), .src_data(src_data),
        .wr_data(wr_data), .wr_en(wr_en)
    );

    reg_bank u_regs (
        .clk(clk), .rst(rst), .cen(cen), .wr_en(wr_en), .regs_we(regs_we),
        .regs_dst(regs_dst), .wr_data(wr_data), .regs_src(regs_src),
        .src_data(src_data), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

endmodule

// File: testbench/tb_cpu_core.sv
`timescale 1ns/10ps

`include "cpu_config.svh"

module tb_cpu_core;

    localparam int MAX_TESTS       = 8;
    localparam int MAX_BYTES       = 16;
    localparam int NUM_LONGS       = 8;   // long registers E0h to FCh
    localparam int CYCLES_PER_TEST = 200;
    localparam logic [7:0] HALT_OP = 8'h01; // undecoded, parks the sequencer

    logic                    clk;
    logic                    rst;
    logic                    cen;
    logic [`CPU_PROG_AW-1:0] prog_addr;
    logic [`CPU_DATA_W-1:0]  prog_data;
    logic                    prog_ok;
    cpu_pkg::reg_addr_t      dbg_addr;
    logic [`CPU_DATA_W-1:0]  dbg_data;

    logic [8*MAX_BYTES-1:0]  prog_bytes [MAX_TESTS]; // first byte in memory is leftmost
    int                      prog_len   [MAX_TESTS];
    bit                      stall_en   [MAX_TESTS];
    int                      cen_hold   [MAX_TESTS];
    logic [`CPU_DATA_W-1:0]  exp_long   [MAX_TESTS][NUM_LONGS];
    int                      n_tests;
    int                      cur_test;
    logic [`CPU_PROG_AW-1:0] last_addr;

    cpu_core UUT (
        .clk(clk), .rst(rst), .cen(cen),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_ok(prog_ok),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [7:0] prog_byte(input int t, input int a);
        if (a >= prog_len[t])
            return HALT_OP;
        return prog_bytes[t][8*(prog_len[t]-1-a) +: 8];
    endfunction

    // four bytes from addr upward, lowest address in the low byte
    function automatic logic [`CPU_DATA_W-1:0] prog_window(input int t,
                                                           input logic [`CPU_PROG_AW-1:0] addr);
        logic [`CPU_DATA_W-1:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = prog_byte(t, int'(addr) + i);
        end
        return w;
    endfunction

    task automatic add_test(input logic [8*MAX_BYTES-1:0] bytes, input int len,
                            input bit stall, input int hold);
        prog_bytes[n_tests] = bytes;
        prog_len[n_tests]   = len;
        stall_en[n_tests]   = stall;
        cen_hold[n_tests]   = hold;
        for (int i = 0; i < NUM_LONGS; i++) begin
            exp_long[n_tests][i] = '0; // untouched registers stay clear
        end
        n_tests++;
    endtask

    task automatic expect_reg(input cpu_pkg::reg_addr_t addr, input logic [`CPU_DATA_W-1:0] val);
        int idx;
        idx = (int'(addr) - int'(`CPU_REG_BASE)) / 4;
        exp_long[n_tests-1][idx] = val;
    endtask

    task automatic build_table();
        n_tests = 0;
        add_test(128'h215a24c3, 4, 1'b0, 0); // LD R,# byte to E0h and E9h
        expect_reg(8'he0, 32'h0000005a);
        expect_reg(8'he8, 32'h0000c300);
        add_test(128'h3234124378563412, 8, 1'b0, 0); // word then long immediate
        expect_reg(8'he8, 32'h00001234);
        expect_reg(8'hec, 32'h12345678);
        add_test(128'h4144332211e98d, 7, 1'b1, 0); // short prefix, LD R,r
        expect_reg(8'he4, 32'h11223344);
        expect_reg(8'hf4, 32'h11223344);
        add_test(128'h4288776655d7f09a, 8, 1'b1, 0); // full prefix, word LD r,R
        expect_reg(8'he8, 32'h55667788);
        expect_reg(8'hf0, 32'h00007788);
        add_test(128'hc8add7f803bebaef03efbeaddecb0377, 16, 1'b0, 0);
        expect_reg(8'he0, 32'h00000500);
        expect_reg(8'he4, 32'h00000077);
        expect_reg(8'hf8, 32'h0000babe);
        expect_reg(8'hfc, 32'hdeadbeef);
        add_test(128'h000000, 3, 1'b1, 0); // NOPs only
        add_test(128'h00215a00, 4, 1'b1, 0);
        expect_reg(8'he0, 32'h0000005a);
        add_test(128'h215a24c3, 4, 1'b1, 6); // same as the first, cen held low
        expect_reg(8'he0, 32'h0000005a);
        expect_reg(8'he8, 32'h0000c300);
    endtask

    task automatic check_addr(input logic [`CPU_PROG_AW-1:0] expected);
        if (prog_addr !== expected) begin
            $display("CHECK FAILED at %0t: prog_addr is %h, expected %h",
                     $time, prog_addr, expected);
            $display("Test failures found");
            $fatal(1, "program address mismatch");
        end
    endtask

    task automatic check_reg(input cpu_pkg::reg_addr_t addr,
                             input logic [`CPU_DATA_W-1:0] expected);
        @(posedge clk);
        #1;
        dbg_addr = addr;
        #2;
        if (dbg_data !== expected) begin
            $display("CHECK FAILED at %0t: dbg_data for register %h is %h, expected %h",
                     $time, addr, dbg_data, expected);
            $display("Test failures found");
            $fatal(1, "register mismatch");
        end
    endtask

    task automatic freeze_cen(input int cycles);
        logic [`CPU_PROG_AW-1:0] frozen;
        frozen = prog_addr;
        cen    = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_addr(frozen);
        end
        cen = 1'b1;
    endtask

    task automatic run_test(input int t);
        bit held;
        held = 1'b0;
        @(posedge clk);
        #1;
        rst      = 1'b1;
        cen      = 1'b1;
        cur_test = t;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        while (int'(prog_addr) != prog_len[t]) begin
            if (!held && cen_hold[t] > 0 && prog_addr != '0) begin
                freeze_cen(cen_hold[t]); // somewhere mid program
                held = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk); // let the last write land
        #1;
        check_addr(`CPU_PROG_AW'(prog_len[t]));
        for (int i = 0; i < NUM_LONGS; i++) begin
            check_reg(`CPU_REG_BASE + 8'(4 * i), exp_long[t][i]);
        end
        $display("test %0d done at %0t", t, $time);
    endtask

    // program memory, answers a cycle after it sees the address
    initial begin
        prog_data = '0;
        prog_ok   = 1'b0;
        last_addr = '0;
        forever begin
            @(posedge clk);
            #1;
            prog_data = prog_window(cur_test, last_addr);
            if (stall_en[cur_test])
                prog_ok = ($urandom % 3) != 0;
            else
                prog_ok = 1'b1;
            last_addr = prog_addr;
        end
    end

    initial begin
        repeat (MAX_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Test failures found");
        $display("watchdog expired, a program never reached its end address");
        $fatal(1, "timeout");
    end

    initial begin
        rst      = 1'b1;
        cen      = 1'b1;
        dbg_addr = `CPU_REG_BASE;
        cur_test = 0;
        void'($urandom(55));
        build_table();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
hdl/cpu_pkg.sv
hdl/op_fetch.sv
hdl/cpu_ctrl.sv
hdl/move_alu.sv
hdl/reg_bank.sv
hdl/cpu_core.sv
testbench/tb_cpu_core.sv

// File: Makefile
TOP = tb_cpu_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
